/* vlog.f */
boot_pkg.sv
boot_reg_pkg.sv
boot_ctrl_if.sv
boot_regs.sv
boot_fsm.sv
boot_ctrl_top.sv
boot_ctrl_checker.sv
tb_boot_ctrl.sv

/* Makefile */
TOP := tb_boot_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run; fails unless the pass message is printed"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

/* tb_boot_ctrl.sv */
// Self-checking testbench for boot_ctrl_top at the default WAIT_W; random stimulus uses a fixed seed
module tb_boot_ctrl;

    localparam logic [31:0] SEED = 32'h40c7;

    // Cycle budgets of the tests, summed with a margin for the watchdog
    localparam int BUDGET_BOOT  = 60;
    localparam int BUDGET_FW    = 80;
    localparam int BUDGET_BRK   = 110;
    localparam int BUDGET_WARM  = 80;
    localparam int BUDGET_PG    = 40;
    localparam int WATCHDOG_CYC = BUDGET_BOOT + BUDGET_FW + BUDGET_BRK + BUDGET_WARM
                                + BUDGET_PG + 200;

    logic                            clk;
    logic                            cptra_pwrgood;
    logic                            cptra_rst_b;
    logic                            reg_valid;
    logic [boot_reg_pkg::REG_AW-1:0] reg_addr;
    logic [boot_reg_pkg::REG_DW-1:0] reg_wdata;
    logic                            reg_ready;
    logic                            ready_for_fuses;
    boot_pkg::boot_state_e           boot_state;
    logic                            noncore_rst_b;
    logic                            uc_rst_b;
    logic                            iccm_unlock;
    logic                            fw_upd_rst_executed;
    logic                            rdc_clk_dis;
    logic                            fw_update_rst_window;
    logic [boot_reg_pkg::REG_DW-1:0] fuse_word;

    // Reference model state, holding the values expected after the last rising edge
    boot_pkg::boot_state_e m_state;
    boot_pkg::boot_state_e m_raw;
    logic                  m_win;
    logic                  m_win_f;
    logic                  m_win_ff;
    logic                  m_snc;
    logic                  m_suc;
    logic                  m_nc;
    logic                  m_uc;
    logic                  m_unlock;
    logic                  m_exec;
    logic [7:0]            m_cnt;

    boot_ctrl_top dut_i (
        .clk                  (clk),
        .cptra_pwrgood        (cptra_pwrgood),
        .cptra_rst_b          (cptra_rst_b),
        .reg_valid            (reg_valid),
        .reg_addr             (reg_addr),
        .reg_wdata            (reg_wdata),
        .reg_ready            (reg_ready),
        .ready_for_fuses      (ready_for_fuses),
        .boot_state           (boot_state),
        .noncore_rst_b        (noncore_rst_b),
        .uc_rst_b             (uc_rst_b),
        .iccm_unlock          (iccm_unlock),
        .fw_upd_rst_executed  (fw_upd_rst_executed),
        .rdc_clk_dis          (rdc_clk_dis),
        .fw_update_rst_window (fw_update_rst_window),
        .fuse_word            (fuse_word)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_state(input boot_pkg::boot_state_e act, input boot_pkg::boot_state_e exp,
                               input string name);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL t=%0t %s actual=%s expected=%s", $time, name,
                                    act.name(), exp.name()));
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL t=%0t %s actual=%b expected=%b", $time, name, act, exp));
        end
    endtask

    task automatic check_word(input logic [boot_reg_pkg::REG_DW-1:0] act,
                              input logic [boot_reg_pkg::REG_DW-1:0] exp,
                              input string name);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL t=%0t %s actual=%h expected=%h", $time, name, act, exp));
        end
    endtask

    // Expected state after one edge, taken from the boot flow rules with the window ignored
    function automatic boot_pkg::boot_state_e next_state(
        input boot_pkg::boot_state_e cur,
        input logic fuse_done,
        input logic fuse_seen,
        input logic brkpoint,
        input logic cont,
        input logic fw_req,
        input logic core_sync,
        input logic cnt_zero
    );
        boot_pkg::boot_state_e nxt;
        nxt = cur;
        case (cur)
            boot_pkg::BOOT_IDLE:   nxt = boot_pkg::BOOT_FUSE;
            boot_pkg::BOOT_FUSE: begin
                if (fuse_done && fuse_seen) begin
                    nxt = brkpoint ? boot_pkg::BOOT_WAIT : boot_pkg::BOOT_DONE;
                end
            end
            boot_pkg::BOOT_FW_RST: begin
                if (!core_sync) begin
                    nxt = boot_pkg::BOOT_WAIT;
                end
            end
            boot_pkg::BOOT_WAIT: begin
                if (cnt_zero && !(brkpoint && !cont)) begin
                    nxt = boot_pkg::BOOT_DONE;
                end
            end
            boot_pkg::BOOT_DONE: begin
                if (fw_req) begin
                    nxt = boot_pkg::BOOT_FW_RST;
                end
            end
            default:               nxt = boot_pkg::BOOT_IDLE;
        endcase
        return nxt;
    endfunction

    // Outputs are compared on the falling edge, where every flop has settled
    always @(negedge clk) begin
        if (!cptra_pwrgood) begin
            m_state  = boot_pkg::BOOT_IDLE;
            m_win_f  = 1'b1;
            m_win_ff = 1'b1;
            m_snc    = 1'b0;
            m_suc    = 1'b0;
            m_nc     = 1'b0;
            m_uc     = 1'b0;
            m_exec   = 1'b0;
        end
        // Warm reset acts at once on the window source, timer and unlock pulse
        if (!cptra_rst_b) begin
            m_win    = 1'b1;
            m_cnt    = '0;
            m_unlock = 1'b0;
        end
        check_state(boot_state, m_state, "boot_state");
        check_bit(noncore_rst_b, m_nc, "noncore_rst_b");
        check_bit(uc_rst_b, m_uc, "uc_rst_b");
        check_bit(iccm_unlock, m_unlock, "iccm_unlock");
        check_bit(fw_upd_rst_executed, m_exec, "fw_upd_rst_executed");
        check_bit(rdc_clk_dis, m_win_f | m_win_ff, "rdc_clk_dis");
        check_bit(reg_ready, ~(m_win_f | m_win_ff), "reg_ready");
        check_bit(ready_for_fuses, m_state == boot_pkg::BOOT_FUSE, "ready_for_fuses");
        check_bit(fw_update_rst_window, (m_state == boot_pkg::BOOT_FW_RST)
                  | (m_state == boot_pkg::BOOT_WAIT), "fw_update_rst_window");
        // Predict the values after the next rising edge from the old model values
        m_raw = next_state(m_state, dut_i.ctrl_if.fuse_done, dut_i.ctrl_if.fuse_wr_done_observed,
                           dut_i.ctrl_if.brkpoint, dut_i.ctrl_if.cont,
                           dut_i.ctrl_if.fw_update_rst, m_suc, m_cnt == 8'd0);
        m_unlock = cptra_rst_b & (m_state == boot_pkg::BOOT_WAIT) & (m_raw == boot_pkg::BOOT_DONE);
        if ((m_state == boot_pkg::BOOT_DONE) && (m_raw == boot_pkg::BOOT_FW_RST)) begin
            m_exec = 1'b1;
        end
        if (!cptra_rst_b) begin
            m_cnt = '0;
        end
        else if ((m_state == boot_pkg::BOOT_WAIT) && (m_cnt != 8'd0)) begin
            m_cnt = m_cnt - 8'd1;
        end
        else if (m_state == boot_pkg::BOOT_FW_RST) begin
            m_cnt = dut_i.ctrl_if.wait_cycles;
        end
        m_uc  = m_snc & m_suc;
        m_nc  = m_snc;
        m_snc = (m_state != boot_pkg::BOOT_IDLE) && (m_state != boot_pkg::BOOT_FUSE);
        m_suc = (m_state == boot_pkg::BOOT_DONE);
        if (m_win_f) begin
            m_state = boot_pkg::BOOT_IDLE;
        end
        else begin
            m_state = m_raw;
        end
        m_win_ff = m_win_f;
        m_win_f  = m_win;
        m_win    = ~cptra_rst_b;
    end

    // Holds the request until the DUT is ready, then drops it after the accepting edge
    task automatic reg_write(input logic [boot_reg_pkg::REG_AW-1:0] addr,
                             input logic [boot_reg_pkg::REG_DW-1:0] data);
        @(posedge clk);
        reg_valid <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(negedge clk);
        while (!reg_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        reg_valid <= 1'b0;
    endtask

    task automatic wait_state(input boot_pkg::boot_state_e s);
        @(negedge clk);
        while (boot_state != s) begin
            @(negedge clk);
        end
    endtask

    // Firmware-update reset, optionally held at the breakpoint until a continue write
    task automatic run_fw_update(input logic [7:0] wait_n, input logic brk, input int hold);
        boot_reg_pkg::boot_reg_word_u word;
        int unlocks;
        int wait_len;
        logic uc_low_seen;
        unlocks     = 0;
        wait_len    = 0;
        uc_low_seen = 1'b0;
        word.raw = '0;
        word.cfg.wait_cycles = wait_n;
        reg_write(boot_reg_pkg::ADDR_WAIT_CFG, word.raw);
        word.raw = '0;
        word.ctrl.fw_update_rst = 1'b1;
        word.ctrl.brkpoint      = brk;
        reg_write(boot_reg_pkg::ADDR_CTRL, word.raw);
        wait_state(boot_pkg::BOOT_FW_RST);
        if (brk) begin
            wait_state(boot_pkg::BOOT_WAIT);
            // The hold runs past the point where the timer alone would end the wait
            repeat (int'(wait_n) + hold) begin
                @(negedge clk);
                check_state(boot_state, boot_pkg::BOOT_WAIT, "boot_state");
            end
            word.raw = '0;
            word.ctrl.brkpoint = 1'b1;
            word.ctrl.cont     = 1'b1;
            reg_write(boot_reg_pkg::ADDR_CTRL, word.raw);
        end
        while (boot_state != boot_pkg::BOOT_DONE) begin
            if (boot_state == boot_pkg::BOOT_WAIT) begin
                wait_len++;
            end
            if (!uc_rst_b && fw_update_rst_window) begin
                uc_low_seen = 1'b1;
            end
            if (iccm_unlock) begin
                unlocks++;
            end
            check_bit(noncore_rst_b, 1'b1, "noncore_rst_b");
            check_bit(fw_upd_rst_executed, 1'b1, "fw_upd_rst_executed");
            @(negedge clk);
        end
        repeat (4) begin
            if (iccm_unlock) begin
                unlocks++;
            end
            @(negedge clk);
        end
        if (!brk && (wait_len < int'(wait_n))) begin
            stop_on_error("The firmware-update wait ended before the configured count");
        end
        if (!uc_low_seen) begin
            stop_on_error("uc_rst_b was never low inside the firmware-update reset window");
        end
        if (unlocks != 1) begin
            stop_on_error($sformatf("iccm_unlock pulsed %0d times instead of once", unlocks));
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        stop_on_error("The watchdog expired before the tests finished");
    end

    initial begin
        logic [boot_reg_pkg::REG_DW-1:0] fuse_val;
        void'($urandom(SEED));
        cptra_pwrgood <= 1'b0;
        cptra_rst_b   <= 1'b0;
        reg_valid     <= 1'b0;
        reg_addr      <= '0;
        reg_wdata     <= '0;
        repeat (5) @(posedge clk);
        cptra_pwrgood <= 1'b1;
        cptra_rst_b   <= 1'b1;

        // Cold boot stops in fuse loading with both resets held
        wait_state(boot_pkg::BOOT_FUSE);
        check_bit(ready_for_fuses, 1'b1, "ready_for_fuses");
        check_bit(noncore_rst_b, 1'b0, "noncore_rst_b");
        check_bit(uc_rst_b, 1'b0, "uc_rst_b");

        // Fuse load, then the word is locked by fuse-done
        fuse_val = $urandom;
        reg_write(boot_reg_pkg::ADDR_FUSE_DATA, fuse_val);
        @(negedge clk);
        check_word(fuse_word, fuse_val, "fuse_word");
        reg_write(boot_reg_pkg::ADDR_FUSE_DONE, 32'h1);
        wait_state(boot_pkg::BOOT_DONE);
        while (!uc_rst_b) begin
            @(negedge clk);
        end
        check_bit(noncore_rst_b, 1'b1, "noncore_rst_b");
        reg_write(boot_reg_pkg::ADDR_FUSE_DATA, ~fuse_val);
        @(negedge clk);
        check_word(fuse_word, fuse_val, "fuse_word");

        run_fw_update(8'($urandom_range(15, 0)), 1'b0, 0);
        run_fw_update(8'($urandom_range(15, 0)), 1'b1, int'($urandom_range(20, 1)));

        // Warm reset keeps the fuse word and the executed flag
        @(posedge clk);
        cptra_rst_b <= 1'b0;
        repeat (4) @(posedge clk);
        cptra_rst_b <= 1'b1;
        @(negedge clk);
        while (noncore_rst_b || uc_rst_b) begin
            @(negedge clk);
        end
        check_bit(rdc_clk_dis, 1'b1, "rdc_clk_dis");
        check_word(fuse_word, fuse_val, "fuse_word");
        check_bit(fw_upd_rst_executed, 1'b1, "fw_upd_rst_executed");
        wait_state(boot_pkg::BOOT_FUSE);
        reg_write(boot_reg_pkg::ADDR_FUSE_DONE, 32'h1);
        wait_state(boot_pkg::BOOT_DONE);

        // Power-good reset clears the fuse word and the executed flag
        @(posedge clk);
        cptra_pwrgood <= 1'b0;
        cptra_rst_b   <= 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_bit(fw_upd_rst_executed, 1'b0, "fw_upd_rst_executed");
        check_word(fuse_word, 32'h0, "fuse_word");
        @(posedge clk);
        cptra_pwrgood <= 1'b1;
        cptra_rst_b   <= 1'b1;
        wait_state(boot_pkg::BOOT_FUSE);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* boot_ctrl_checker.sv */
// Concurrent checks on boot_fsm reset ordering; all are disabled while cptra_pwrgood is low
module boot_ctrl_checker (
    input logic                  clk,
    input logic                  cptra_pwrgood,
    input logic                  noncore_rst_b,
    input logic                  uc_rst_b,
    input logic                  iccm_unlock,
    input logic                  rdc_clk_dis,
    input logic                  fw_update_rst_window,
    input boot_pkg::boot_state_e boot_state
);

    // The non-core reset only drops inside the reset-domain-crossing window
    noncore_fall_a: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        $fell(noncore_rst_b) |-> rdc_clk_dis)
        else $error("noncore_rst_b fell with rdc_clk_dis low");

    // The core reset drops for a warm reset or a firmware-update reset, never elsewhere
    uc_fall_a: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        $fell(uc_rst_b) |-> (rdc_clk_dis || fw_update_rst_window))
        else $error("uc_rst_b fell outside the reset windows");

    unlock_pulse_a: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        $rose(iccm_unlock) |=> !iccm_unlock)
        else $error("iccm_unlock stayed high for more than one cycle");

    state_known_a: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        !$isunknown(boot_state))
        else $error("boot_state is unknown");

endmodule

bind boot_fsm boot_ctrl_checker checker_i (
    .clk                  (clk),
    .cptra_pwrgood        (cptra_pwrgood),
    .noncore_rst_b        (noncore_rst_b),
    .uc_rst_b             (uc_rst_b),
    .iccm_unlock          (iccm_unlock),
    .rdc_clk_dis          (ctrl.rdc_clk_dis),
    .fw_update_rst_window (fw_update_rst_window),
    .boot_state           (boot_state)
);

/* boot_ctrl_top.sv */
// Boot sequencer top; register writes are accepted only while reg_ready is high
module boot_ctrl_top #(
    parameter int WAIT_W = boot_pkg::WAIT_W
) (
    input  logic                            clk,
    input  logic                            cptra_pwrgood,
    input  logic                            cptra_rst_b,
    input  logic                            reg_valid,
    input  logic [boot_reg_pkg::REG_AW-1:0] reg_addr,
    input  logic [boot_reg_pkg::REG_DW-1:0] reg_wdata,
    output logic                            reg_ready,
    output logic                            ready_for_fuses,
    output boot_pkg::boot_state_e           boot_state,
    output logic                            noncore_rst_b,
    output logic                            uc_rst_b,
    output logic                            iccm_unlock,
    output logic                            fw_upd_rst_executed,
    output logic                            rdc_clk_dis,
    output logic                            fw_update_rst_window,
    output logic [boot_reg_pkg::REG_DW-1:0] fuse_word
);

    // Controls shared by the register block and the FSM
    boot_ctrl_if #(.WAIT_W(WAIT_W)) ctrl_if ();

    // FSM status that also leaves the block as plain ports
    assign ready_for_fuses = ctrl_if.ready_for_fuses;
    assign rdc_clk_dis     = ctrl_if.rdc_clk_dis;

    boot_regs #(.WAIT_W(WAIT_W)) regs_i (
        .clk           (clk),
        .cptra_pwrgood (cptra_pwrgood),
        .cptra_rst_b   (cptra_rst_b),
        .reg_valid     (reg_valid),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_ready     (reg_ready),
        .fuse_word     (fuse_word),
        .ctrl          (ctrl_if.regs)
    );

    boot_fsm #(.WAIT_W(WAIT_W)) fsm_i (
        .clk                  (clk),
        .cptra_pwrgood        (cptra_pwrgood),
        .cptra_rst_b          (cptra_rst_b),
        .ctrl                 (ctrl_if.fsm),
        .boot_state           (boot_state),
        .noncore_rst_b        (noncore_rst_b),
        .uc_rst_b             (uc_rst_b),
        .iccm_unlock          (iccm_unlock),
        .fw_upd_rst_executed  (fw_upd_rst_executed),
        .fw_update_rst_window (fw_update_rst_window)
    );

endmodule

/* boot_fsm.sv */
// Boot FSM with reset generation; cptra_rst_b must be low whenever cptra_pwrgood is low
module boot_fsm #(
    parameter int WAIT_W = boot_pkg::WAIT_W
) (
    input  logic                 clk,
    input  logic                 cptra_pwrgood,
    input  logic                 cptra_rst_b,
    boot_ctrl_if.fsm             ctrl,
    output boot_pkg::boot_state_e boot_state,
    output logic                 noncore_rst_b,
    output logic                 uc_rst_b,
    output logic                 iccm_unlock,
    output logic                 fw_upd_rst_executed,
    output logic                 fw_update_rst_window
);

    boot_pkg::boot_state_e state_next;

    // Reset release requests from the FSM, before synchronization
    logic noncore_rel;
    logic uc_rel;

    // First synchronizer stage of each generated reset
    logic sync_noncore_rst_b;
    logic sync_uc_rst_b;

    // Wait timer controls and the unlock request
    logic              wait_load;
    logic              wait_dec;
    logic [WAIT_W-1:0] wait_cnt;
    logic              unlock_next;
    logic              fw_exec_set;

    // Reset window and its two delayed copies
    logic rst_window;
    logic rst_window_f;
    logic rst_window_ff;

    // Register writes and clocks of the other domains are held off across the window
    assign ctrl.rdc_clk_dis = rst_window_f | rst_window_ff;

    // Marks the span in which only the microcontroller reset is asserted
    assign fw_update_rst_window = (boot_state == boot_pkg::BOOT_FW_RST)
                                | (boot_state == boot_pkg::BOOT_WAIT);

    always_comb begin
        state_next           = boot_state;
        ctrl.ready_for_fuses = 1'b0;
        noncore_rel          = 1'b0;
        uc_rel               = 1'b0;
        wait_load            = 1'b0;
        wait_dec             = 1'b0;
        unlock_next          = 1'b0;
        fw_exec_set          = 1'b0;
        case (boot_state)
            boot_pkg::BOOT_IDLE: begin
                // Leave once the delayed reset window has closed
                if (!rst_window_f) begin
                    state_next = boot_pkg::BOOT_FUSE;
                end
            end
            boot_pkg::BOOT_FUSE: begin
                ctrl.ready_for_fuses = 1'b1;
                // A breakpoint keeps the core in reset through the wait state
                if (ctrl.fuse_done && ctrl.fuse_wr_done_observed) begin
                    state_next = ctrl.brkpoint ? boot_pkg::BOOT_WAIT : boot_pkg::BOOT_DONE;
                end
            end
            boot_pkg::BOOT_FW_RST: begin
                noncore_rel = 1'b1;
                wait_load   = 1'b1;
                // Move on once the core reset has reached the first synchronizer stage
                if (!sync_uc_rst_b) begin
                    state_next = boot_pkg::BOOT_WAIT;
                end
            end
            boot_pkg::BOOT_WAIT: begin
                noncore_rel = 1'b1;
                wait_dec    = 1'b1;
                // The ICCM unlocks only at the end of the reset flow
                if ((wait_cnt == '0) && !(ctrl.brkpoint && !ctrl.cont)) begin
                    state_next  = boot_pkg::BOOT_DONE;
                    unlock_next = 1'b1;
                end
            end
            boot_pkg::BOOT_DONE: begin
                noncore_rel = 1'b1;
                uc_rel      = 1'b1;
                if (ctrl.fw_update_rst) begin
                    state_next  = boot_pkg::BOOT_FW_RST;
                    fw_exec_set = 1'b1;
                end
            end
            default: begin
                state_next = boot_pkg::BOOT_IDLE;
            end
        endcase
    end

    // State, reset synchronizers and delayed window copies in the power-good domain
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            boot_state          <= boot_pkg::BOOT_IDLE;
            sync_noncore_rst_b  <= 1'b0;
            sync_uc_rst_b       <= 1'b0;
            noncore_rst_b       <= 1'b0;
            uc_rst_b            <= 1'b0;
            fw_upd_rst_executed <= 1'b0;
            rst_window_f        <= 1'b1;
            rst_window_ff       <= 1'b1;
        end
        else begin
            // An open window forces the FSM back to idle
            boot_state         <= rst_window_f ? boot_pkg::BOOT_IDLE : state_next;
            sync_noncore_rst_b <= noncore_rel;
            sync_uc_rst_b      <= uc_rel;
            noncore_rst_b      <= sync_noncore_rst_b;
            // The core leaves reset only when neither reset holds it
            uc_rst_b           <= sync_noncore_rst_b & sync_uc_rst_b;
            // Sticky, so firmware can tell a firmware-update reset from a warm one
            if (fw_exec_set) begin
                fw_upd_rst_executed <= 1'b1;
            end
            rst_window_f  <= rst_window;
            rst_window_ff <= rst_window_f;
        end
    end

    // Window source, wait timer and unlock pulse in the warm-reset domain
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rst_window  <= 1'b1;
            wait_cnt    <= '0;
            iccm_unlock <= 1'b0;
        end
        else begin
            rst_window  <= 1'b0;
            iccm_unlock <= unlock_next;
            if (wait_dec && (wait_cnt != '0)) begin
                wait_cnt <= wait_cnt - WAIT_W'(1);
            end
            else if (wait_load) begin
                wait_cnt <= ctrl.wait_cycles;
            end
        end
    end

endmodule

/* boot_regs.sv */
// Write-only boot registers; writes stall while rdc_clk_dis is high, no read path exists
module boot_regs #(
    parameter int WAIT_W = boot_pkg::WAIT_W
) (
    input  logic                            clk,
    input  logic                            cptra_pwrgood,
    input  logic                            cptra_rst_b,
    input  logic                            reg_valid,
    input  logic [boot_reg_pkg::REG_AW-1:0] reg_addr,
    input  logic [boot_reg_pkg::REG_DW-1:0] reg_wdata,
    output logic                            reg_ready,
    output logic [boot_reg_pkg::REG_DW-1:0] fuse_word,
    boot_ctrl_if.regs                       ctrl
);

    // Write data seen through its decoded views
    boot_reg_pkg::boot_reg_word_u wr_word;

    // Accepted write and its per-address strobes
    logic wr_en;
    logic fuse_data_wr;
    logic fuse_done_wr;
    logic ctrl_wr;
    logic cfg_wr;

    assign wr_word = boot_reg_pkg::boot_reg_word_u'(reg_wdata);

    // Writes wait out the reset-domain-crossing window so no flop is
    // updated while the clocks of the other domain are disabled
    assign reg_ready = ~ctrl.rdc_clk_dis;
    assign wr_en     = reg_valid & reg_ready;

    // Fuse data is only taken while the FSM is loading fuses and before fuse-done,
    // which locks the word for the rest of the power cycle
    assign fuse_data_wr = wr_en & (reg_addr == boot_reg_pkg::ADDR_FUSE_DATA)
                        & ctrl.ready_for_fuses & ~ctrl.fuse_done;

    // Bit 0 of the fuse-done register carries the done flag
    assign fuse_done_wr = wr_en & (reg_addr == boot_reg_pkg::ADDR_FUSE_DONE)
                        & wr_word.raw[0];

    assign ctrl_wr = wr_en & (reg_addr == boot_reg_pkg::ADDR_CTRL);
    assign cfg_wr  = wr_en & (reg_addr == boot_reg_pkg::ADDR_WAIT_CFG);

    // Fuse state lives in the power-good domain and survives warm reset
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            fuse_word      <= '0;
            ctrl.fuse_done <= 1'b0;
        end
        else begin
            if (fuse_data_wr) begin
                fuse_word <= wr_word.raw;
            end
            // Sticky until the next power-good reset
            if (fuse_done_wr) begin
                ctrl.fuse_done <= 1'b1;
            end
        end
    end

    // Control bits live in the warm-reset domain
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            ctrl.fuse_wr_done_observed <= 1'b0;
            ctrl.fw_update_rst         <= 1'b0;
            ctrl.brkpoint              <= 1'b0;
            ctrl.cont                  <= 1'b0;
            ctrl.wait_cycles           <= '0;
        end
        else begin
            // After a warm reset fuse_done is still set, so the FSM waits
            // for a fresh fuse-done write before leaving fuse loading
            if (fuse_done_wr) begin
                ctrl.fuse_wr_done_observed <= 1'b1;
            end
            // Self-clearing request, high for exactly one cycle per write
            ctrl.fw_update_rst <= ctrl_wr & wr_word.ctrl.fw_update_rst;
            if (ctrl_wr) begin
                ctrl.brkpoint <= wr_word.ctrl.brkpoint;
                ctrl.cont     <= wr_word.ctrl.cont;
            end
            if (cfg_wr) begin
                ctrl.wait_cycles <= WAIT_W'(wr_word.cfg.wait_cycles);
            end
        end
    end

endmodule

/* boot_ctrl_if.sv */
// Controls between register block and boot FSM; carries no clock, both sides share clk
interface boot_ctrl_if #(
    parameter int WAIT_W = boot_pkg::WAIT_W
) ();

    // Sticky fuse-done flag, kept across warm reset
    logic              fuse_done;
    // Fuse-done write seen since the last warm reset
    logic              fuse_wr_done_observed;
    // One-cycle firmware-update reset request
    logic              fw_update_rst;
    // Debug breakpoint and continue bits
    logic              brkpoint;
    logic              cont;
    // Configured length of the firmware-update wait
    logic [WAIT_W-1:0] wait_cycles;

    // FSM is in fuse loading, fuse data writes are allowed
    logic              ready_for_fuses;
    // Reset-domain-crossing window, register writes are held off
    logic              rdc_clk_dis;

    // Register block side
    modport regs (
        output fuse_done, fuse_wr_done_observed, fw_update_rst, brkpoint, cont, wait_cycles,
        input  ready_for_fuses, rdc_clk_dis
    );

    // Boot FSM side
    modport fsm (
        input  fuse_done, fuse_wr_done_observed, fw_update_rst, brkpoint, cont, wait_cycles,
        output ready_for_fuses, rdc_clk_dis
    );

endinterface

/* boot_reg_pkg.sv */
// Register map of the boot control block; write-only, one fuse word, unused addresses ignored
package boot_reg_pkg;

    // Register address and data widths
    parameter int REG_AW = 4;
    parameter int REG_DW = 32;

    // Register addresses
    parameter logic [REG_AW-1:0] ADDR_FUSE_DATA = 4'h0;
    parameter logic [REG_AW-1:0] ADDR_FUSE_DONE = 4'h1;
    parameter logic [REG_AW-1:0] ADDR_CTRL      = 4'h2;
    parameter logic [REG_AW-1:0] ADDR_WAIT_CFG  = 4'h3;

    // Control view of a write word, bit 0 requests a firmware-update reset
    // Bit 1 is the debug breakpoint and bit 2 the continue bit
    typedef struct packed {
        logic [28:0] rsvd;
        logic        cont;
        logic        brkpoint;
        logic        fw_update_rst;
    } boot_ctrl_bits_t;

    // Configuration view of a write word, the low byte is the wait length in cycles
    typedef struct packed {
        logic [23:0] rsvd;
        logic [7:0]  wait_cycles;
    } boot_wait_cfg_t;

    // One write word, decoded by address as raw data, control bits or wait configuration
    typedef union packed {
        logic [REG_DW-1:0] raw;
        boot_ctrl_bits_t   ctrl;
        boot_wait_cfg_t    cfg;
    } boot_reg_word_u;

endpackage

/* boot_pkg.sv */
// Boot sequencer state type and defaults; the state encoding is fixed at three bits
package boot_pkg;

    // Width of the boot state register, fixed by the five-state encoding
    parameter int BOOT_STATE_W = 3;

    // Default width of the firmware-update wait counter
    // The register block stores an eight-bit count, so wider counters only zero-extend it
    parameter int WAIT_W = 8;

    // Boot FSM states
    // BOOT_IDLE is held while the reset window is open
    // BOOT_FUSE accepts fuse writes until fuse-done has been observed
    // BOOT_FW_RST asserts the microcontroller reset for a firmware update
    // BOOT_WAIT runs the timed wait and honours the debug breakpoint
    // BOOT_DONE is the normal running state with both resets released
    typedef enum logic [BOOT_STATE_W-1:0] {
        BOOT_IDLE   = 3'd0,
        BOOT_FUSE   = 3'd1,
        BOOT_FW_RST = 3'd2,
        BOOT_WAIT   = 3'd3,
        BOOT_DONE   = 3'd4
    } boot_state_e;

    // Encodings 5 to 7 are unused and recover to BOOT_IDLE in the FSM

endpackage
